/* spec_correlator.f */
corr_pkg.sv
bin_if.sv
dft4_frame.sv
xcorr_accum.sv
dump_credit_tx.sv
spec_correlator.sv
tb_clkgen.sv
spec_correlator_tb.sv

/* Bender.yml */
package:
  name: spec_correlator

sources:
  - corr_pkg.sv
  - bin_if.sv
  - dft4_frame.sv
  - xcorr_accum.sv
  - dump_credit_tx.sv
  - spec_correlator.sv
  - target: simulation
    files:
      - tb_clkgen.sv
      - spec_correlator_tb.sv

/* spec_correlator_tb.sv */
`default_nettype none

module spec_correlator_tb import corr_pkg::*; ();

    logic                    clk;
    logic                    rst;
    logic                    din_valid;
    logic signed [din_w-1:0] din0;
    logic signed [din_w-1:0] din1;
    logic [31:0]             acc_len;
    logic                    credit_return = 1'b0;
    logic                    out_valid;
    bin_idx_t                out_bin;
    logic signed [acc_w-1:0] out_r11;
    logic signed [acc_w-1:0] out_r22;
    logic signed [acc_w-1:0] out_r12_re;
    logic signed [acc_w-1:0] out_r12_im;
    logic                    ovf;
    dump_rec_t               got_rec;
    dump_rec_t               exp_head;

    dump_rec_t exp_q[$];
    int        s0_q[$];
    int        s1_q[$];
    string     cur_test = "startup";
    int        errors = 0;
    int        checks = 0;
    int        tests = 0;
    int        failed_tests = 0;
    int        err_mark = 0;
    int        rx_cnt = 0;
    int        owed = 0;
    bit        hold_credits = 1'b0;
    int        base;

    tb_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    spec_correlator dut0 (
        .clk           (clk),
        .rst           (rst),
        .din_valid     (din_valid),
        .din0          (din0),
        .din1          (din1),
        .acc_len       (acc_len),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_bin       (out_bin),
        .out_r11       (out_r11),
        .out_r22       (out_r22),
        .out_r12_re    (out_r12_re),
        .out_r12_im    (out_r12_im),
        .ovf           (ovf)
    );

    assign got_rec = {out_bin, out_r11, out_r22, out_r12_re, out_r12_im};

    // one bin of the 4-point DFT selected by k
    function automatic void dft_bin(input int a, input int b, input int c, input int d,
                                    input int k, output longint re, output longint im);
        re = 0;
        im = 0;
        case (k)
            0: re = a + b + c + d;
            1: begin
                re = a - c;
                im = -(b - d);
            end
            2: re = a - b + c - d;
            default: begin
                re = a - c;
                im = b - d;
            end
        endcase
    endfunction

    // expected record for one bin over the first len frames in s0_q and s1_q
    function automatic dump_rec_t ref_rec(input int bin, input int len);
        dump_rec_t r;
        longint    x0r;
        longint    x0i;
        longint    x1r;
        longint    x1i;
        longint    a11;
        longint    a22;
        longint    a12r;
        longint    a12i;
        int        i;
        a11  = 0;
        a22  = 0;
        a12r = 0;
        a12i = 0;
        for (int f = 0; f < len; f++) begin
            i = 4 * f;
            dft_bin(s0_q[i], s0_q[i+1], s0_q[i+2], s0_q[i+3], bin, x0r, x0i);
            dft_bin(s1_q[i], s1_q[i+1], s1_q[i+2], s1_q[i+3], bin, x1r, x1i);
            a11  += x0r * x0r + x0i * x0i;
            a22  += x1r * x1r + x1i * x1i;
            // ch0 times conj(ch1)
            a12r += x0r * x1r + x0i * x1i;
            a12i += x0i * x1r - x0r * x1i;
        end
        r.bin    = bin_idx_t'(bin);
        r.r11    = acc_w'(a11);
        r.r22    = acc_w'(a22);
        r.r12_re = acc_w'(a12r);
        r.r12_im = acc_w'(a12i);
        return r;
    endfunction

    // 0 constant, 1 alternating, 2 impulse, else random
    function automatic int pattern(input int kind, input int ch, input int idx);
        logic signed [din_w-1:0] r;
        case (kind)
            0: return (ch == 0) ? 1000 : -700;
            1: return ((idx % 2 == 0) ? 1 : -1) * ((ch == 0) ? 1200 : -500);
            2: return (ch == 0) ? ((idx == 0) ? 3000 : 0) : ((idx == 1) ? -2500 : 0);
            default: begin
                r = din_w'($urandom);
                return int'(r);
            end
        endcase
    endfunction

    task automatic compare_rec(input string name, input dump_rec_t exp, input dump_rec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected bin %0d r11 %0d r22 %0d r12 %0d %0d, %s",
                name, exp.bin, exp.r11, exp.r22, exp.r12_re, exp.r12_im,
                $sformatf("actual bin %0d r11 %0d r22 %0d r12 %0d %0d",
                    act.bin, act.r11, act.r22, act.r12_re, act.r12_im));
        end
    endtask

    task automatic compare_flag(input string name, input string what, input logic exp,
                                input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s: expected %s %0b actual %0b", name, what, exp, act);
        end
    endtask

    task automatic abort(input string msg);
        $display("%s: %s", cur_test, msg);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid) begin
            rx_cnt++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: record for bin %0d arrived with none expected", cur_test, out_bin);
            end else begin
                exp_head = exp_q.pop_front();
                compare_rec(cur_test, exp_head, got_rec);
            end
        end
    end

    // receiver side of the credit loop
    always @(posedge clk) begin
        if (rst) begin
            owed = 0;
            credit_return <= 1'b0;
        end else begin
            if (out_valid) begin
                owed++;
            end
            if (owed > credit_max) begin
                errors++;
                $display("%s: %0d records outstanding, above the credit limit", cur_test, owed);
            end
            if (!hold_credits && owed > 0 && $urandom % 2 == 0) begin
                credit_return <= 1'b1;
                owed--;
            end else begin
                credit_return <= 1'b0;
            end
        end
    end

    task automatic drive_sample(input int a, input int b, input bit gaps);
        int idle;
        idle = gaps ? $urandom % 3 : 0;
        repeat (idle) begin
            @(posedge clk);
            din_valid <= 1'b0;
        end
        @(posedge clk);
        din_valid <= 1'b1;
        din0      <= din_w'(a);
        din1      <= din_w'(b);
    endtask

    task automatic run_integration(input int len, input int kind, input bit gaps);
        int eff;
        int v0;
        int v1;
        eff = (len == 0) ? 1 : len;
        s0_q.delete();
        s1_q.delete();
        @(posedge clk);
        acc_len <= len;
        for (int i = 0; i < 4 * eff; i++) begin
            v0 = pattern(kind, 0, i % 4);
            v1 = pattern(kind, 1, i % 4);
            s0_q.push_back(v0);
            s1_q.push_back(v1);
            drive_sample(v0, v1, gaps);
        end
        @(posedge clk);
        din_valid <= 1'b0;
        for (int b = 0; b < n_bins; b++) begin
            exp_q.push_back(ref_rec(b, eff));
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 3000) abort("timed out waiting for the expected records");
        end while (exp_q.size() != 0 || owed != 0);
    endtask

    task automatic wait_records(input int target);
        int n;
        n = 0;
        while (rx_cnt < target) begin
            @(negedge clk);
            n++;
            if (n > 2000) abort("timed out waiting for records to arrive");
        end
    endtask

    task automatic wait_ovf();
        int n;
        n = 0;
        while (ovf !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 500) abort("overflow flag never rose with the queue overfilled");
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == err_mark) begin
            $display("test %-16s ok", cur_test);
        end else begin
            failed_tests++;
            $display("test %-16s failed with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    initial begin
        int n;
        void'($urandom(19));
        din_valid = 1'b0;
        din0      = '0;
        din1      = '0;
        acc_len   = 32'd1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 20) abort("reset was never released");
        end while (rst);

        start_test("reset_idle");
        repeat (20) begin
            @(negedge clk);
            compare_flag(cur_test, "out_valid", 1'b0, out_valid);
            compare_flag(cur_test, "ovf", 1'b0, ovf);
        end
        finish_test();

        start_test("fixed_patterns");
        for (int k = 0; k < 3; k++) begin
            run_integration(1, k, 1'b0);
        end
        wait_drain();
        finish_test();

        start_test("random_len3");
        repeat (3) run_integration(3, 3, 1'b1);
        wait_drain();
        finish_test();

        // zero counts as one frame
        start_test("len_changes");
        run_integration(2, 3, 1'b1);
        run_integration(0, 3, 1'b1);
        run_integration(4, 3, 1'b0);
        run_integration(1, 3, 1'b1);
        wait_drain();
        finish_test();

        start_test("credit_hold");
        hold_credits = 1'b1;
        base = rx_cnt;
        run_integration(1, 3, 1'b0);
        run_integration(1, 3, 1'b0);
        wait_records(base + credit_max);
        repeat (40) @(negedge clk);
        if (rx_cnt - base != credit_max) begin
            errors++;
            $display("%s: %0d records sent while credits were held", cur_test, rx_cnt - base);
        end
        hold_credits = 1'b0;
        wait_drain();
        compare_flag(cur_test, "ovf", 1'b0, ovf);
        finish_test();

        // four go out on credit, eight fill the queue, the rest drop
        start_test("overflow");
        hold_credits = 1'b1;
        base = rx_cnt;
        repeat (4) run_integration(1, 3, 1'b0);
        wait_ovf();
        hold_credits = 1'b0;
        wait_records(base + credit_max + queue_depth);
        exp_q.delete();
        wait_drain();
        compare_flag(cur_test, "ovf", 1'b1, ovf);
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* spec_correlator.sv */
`default_nettype none

module spec_correlator import corr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    din_valid,
    input  logic signed [din_w-1:0] din0,
    input  logic signed [din_w-1:0] din1,
    input  logic [31:0]             acc_len,
    input  logic                    credit_return,
    output logic                    out_valid,
    output bin_idx_t                out_bin,
    output logic signed [acc_w-1:0] out_r11,
    output logic signed [acc_w-1:0] out_r22,
    output logic signed [acc_w-1:0] out_r12_re,
    output logic signed [acc_w-1:0] out_r12_im,
    output logic                    ovf
);

    dump_rec_t rec;
    dump_rec_t out_rec;
    logic      rec_valid;

    bin_if spec0 ();
    bin_if spec1 ();

    dft4_frame u_dft0 (
        .clk       (clk),
        .rst       (rst),
        .din_valid (din_valid),
        .din       (din0),
        .spec      (spec0.tx)
    );

    dft4_frame u_dft1 (
        .clk       (clk),
        .rst       (rst),
        .din_valid (din_valid),
        .din       (din1),
        .spec      (spec1.tx)
    );

    xcorr_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .spec0     (spec0.rx),
        .spec1     (spec1.rx),
        .acc_len   (acc_len),
        .rec       (rec),
        .rec_valid (rec_valid)
    );

    dump_credit_tx u_tx (
        .clk           (clk),
        .rst           (rst),
        .rec           (rec),
        .rec_valid     (rec_valid),
        .credit_return (credit_return),
        .out_rec       (out_rec),
        .out_valid     (out_valid),
        .ovf           (ovf)
    );

    assign out_bin    = out_rec.bin;
    assign out_r11    = out_rec.r11;
    assign out_r22    = out_rec.r22;
    assign out_r12_re = out_rec.r12_re;
    assign out_r12_im = out_rec.r12_im;

endmodule

`default_nettype wire

/* dump_credit_tx.sv */
`default_nettype none

module dump_credit_tx import corr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dump_rec_t rec,
    input  logic      rec_valid,
    input  logic      credit_return,
    output dump_rec_t out_rec,
    output logic      out_valid,
    output logic      ovf
);

    dump_rec_t           mem [queue_depth];
    logic [q_ptr_w-1:0]  wr_ptr;
    logic [q_ptr_w-1:0]  rd_ptr;
    logic [q_ptr_w:0]    count;
    logic [credit_w-1:0] credits;
    logic                full;
    logic                push;
    logic                pop;

    assign full = count == queue_depth;
    assign push = rec_valid && !full;
    // drain one per cycle while credits remain
    assign pop  = count != '0 && credits != '0;

    assign out_valid = pop;
    assign out_rec   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= credit_w'(credit_max);
            ovf     <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            unique case ({pop, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
            // sticky until reset
            if (rec_valid && full) begin
                ovf <= 1'b1;
            end
        end
    end

    // receiver must not return more than it was sent
    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_max);

endmodule

`default_nettype wire

/* xcorr_accum.sv */
`default_nettype none

module xcorr_accum import corr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    bin_if.rx           spec0,
    bin_if.rx           spec1,
    input  logic [31:0] acc_len,
    output dump_rec_t   rec,
    output logic        rec_valid
);

    logic signed [2*bin_w:0] m11;
    logic signed [2*bin_w:0] m22;
    logic signed [2*bin_w:0] m12_re;
    logic signed [2*bin_w:0] m12_im;
    logic [31:0]             eff_len;
    logic [31:0]             cur_len;
    logic [31:0]             len_q;
    logic [31:0]             frame_cnt;
    logic                    frame_first;
    logic                    frame_last;

    // product stage
    logic                    p_valid;
    logic                    p_first;
    logic                    p_dump;
    bin_idx_t                p_bin;
    logic signed [acc_w-1:0] p11;
    logic signed [acc_w-1:0] p22;
    logic signed [acc_w-1:0] p12_re;
    logic signed [acc_w-1:0] p12_im;

    logic signed [acc_w-1:0] acc11 [n_bins];
    logic signed [acc_w-1:0] acc22 [n_bins];
    logic signed [acc_w-1:0] acc12_re [n_bins];
    logic signed [acc_w-1:0] acc12_im [n_bins];

    logic                    dump_load;
    bin_idx_t                dump_cnt;
    bin_idx_t                dump_idx;

    // ch0 times conj(ch1)
    assign m11    = spec0.re * spec0.re + spec0.im * spec0.im;
    assign m22    = spec1.re * spec1.re + spec1.im * spec1.im;
    assign m12_re = spec0.re * spec1.re + spec0.im * spec1.im;
    assign m12_im = spec0.im * spec1.re - spec0.re * spec1.im;

    assign eff_len     = (acc_len == '0) ? 32'd1 : acc_len;
    assign frame_first = frame_cnt == '0;
    assign cur_len     = (frame_first && spec0.bin == '0) ? eff_len : len_q;
    assign frame_last  = frame_cnt == cur_len - 32'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            p_valid   <= 1'b0;
            frame_cnt <= '0;
            len_q     <= 32'd1;
        end else begin
            p_valid <= spec0.valid;
            if (spec0.valid) begin
                if (frame_first && spec0.bin == '0) begin
                    len_q <= eff_len;
                end
                if (spec0.bin == 2'd3) begin
                    frame_cnt <= frame_last ? '0 : frame_cnt + 32'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        p_bin   <= spec0.bin;
        p_first <= frame_first;
        p_dump  <= frame_last && spec0.bin == 2'd3;
        p11     <= m11;
        p22     <= m22;
        p12_re  <= m12_re;
        p12_im  <= m12_im;
    end

    // first frame overwrites, so totals restart without a clear cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < n_bins; i++) begin
                acc11[i]    <= '0;
                acc22[i]    <= '0;
                acc12_re[i] <= '0;
                acc12_im[i] <= '0;
            end
        end else if (p_valid) begin
            acc11[p_bin]    <= p_first ? p11 : acc11[p_bin] + p11;
            acc22[p_bin]    <= p_first ? p22 : acc22[p_bin] + p22;
            acc12_re[p_bin] <= p_first ? p12_re : acc12_re[p_bin] + p12_re;
            acc12_im[p_bin] <= p_first ? p12_im : acc12_im[p_bin] + p12_im;
        end
    end

    assign dump_load = (p_valid && p_dump) || (rec_valid && dump_cnt != '0);
    assign dump_idx  = (p_valid && p_dump) ? '0 : dump_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
            dump_cnt  <= '0;
        end else begin
            rec_valid <= dump_load;
            if (dump_load) begin
                dump_cnt <= dump_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dump_load) begin
            rec.bin    <= dump_idx;
            rec.r11    <= acc11[dump_idx];
            rec.r22    <= acc22[dump_idx];
            rec.r12_re <= acc12_re[dump_idx];
            rec.r12_im <= acc12_im[dump_idx];
        end
    end

    // both transforms run off one valid
    a_chan_aligned: assert property (@(posedge clk) disable iff (rst)
        spec0.valid == spec1.valid && (!spec0.valid || spec0.bin == spec1.bin));

endmodule

`default_nettype wire

/* dft4_frame.sv */
`default_nettype none

module dft4_frame import corr_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    din_valid,
    input  logic signed [din_w-1:0] din,
    bin_if.tx                       spec
);

    // two frame buffers, one filling while the other is read
    logic signed [din_w-1:0] smp_buf [2][n_bins];
    bin_idx_t                wr_cnt;
    logic                    wr_sel;
    logic                    rd_sel;
    logic                    start;
    logic                    out_busy;
    bin_idx_t                out_cnt;
    logic signed [bin_w-1:0] sa;
    logic signed [bin_w-1:0] sb;
    logic signed [bin_w-1:0] sc;
    logic signed [bin_w-1:0] sd;

    assign start = din_valid && wr_cnt == 2'd3;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            smp_buf[wr_sel][wr_cnt] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt   <= '0;
            wr_sel   <= 1'b0;
            rd_sel   <= 1'b0;
            out_busy <= 1'b0;
            out_cnt  <= '0;
        end else begin
            if (din_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (start) begin
                    wr_sel <= ~wr_sel;
                end
            end
            if (start) begin
                out_busy <= 1'b1;
                out_cnt  <= '0;
                rd_sel   <= wr_sel;
            end else if (out_busy) begin
                out_cnt <= out_cnt + 1'b1;
                if (out_cnt == 2'd3) begin
                    out_busy <= 1'b0;
                end
            end
        end
    end

    // sign extend before summing
    assign sa = smp_buf[rd_sel][0];
    assign sb = smp_buf[rd_sel][1];
    assign sc = smp_buf[rd_sel][2];
    assign sd = smp_buf[rd_sel][3];

    always_comb begin
        spec.re = '0;
        spec.im = '0;
        unique case (out_cnt)
            2'd0: spec.re = sa + sb + sc + sd;
            2'd1: begin
                spec.re = sa - sc;
                spec.im = sd - sb;
            end
            2'd2: spec.re = sa - sb + sc - sd;
            default: begin
                spec.re = sa - sc;
                spec.im = sb - sd;
            end
        endcase
    end

    assign spec.valid = out_busy;
    assign spec.bin   = out_cnt;

    // a full frame may only complete on the last bin of the previous burst
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start |-> !out_busy || out_cnt == 2'd3);

endmodule

`default_nettype wire

/* bin_if.sv */
`default_nettype none

interface bin_if import corr_pkg::*; ();

    logic                    valid;
    bin_idx_t                bin;
    logic signed [bin_w-1:0] re;
    logic signed [bin_w-1:0] im;

    modport tx (
        output valid,
        output bin,
        output re,
        output im
    );

    modport rx (
        input valid,
        input bin,
        input re,
        input im
    );

endinterface

`default_nettype wire

/* corr_pkg.sv */
`default_nettype none

package corr_pkg;

    // input sample width
    localparam int din_w = 16;
    // four samples summed, two bits of growth
    localparam int bin_w = 18;
    localparam int n_bins = 4;
    localparam int acc_w = 48;

    // output port flow control
    localparam int credit_max = 4;
    localparam int credit_w = $clog2(credit_max + 1);
    localparam int queue_depth = 8;
    localparam int q_ptr_w = $clog2(queue_depth);

    typedef logic [1:0] bin_idx_t;

    // one integrated record per bin
    typedef struct packed {
        bin_idx_t                bin;
        logic signed [acc_w-1:0] r11;
        logic signed [acc_w-1:0] r22;
        logic signed [acc_w-1:0] r12_re;
        logic signed [acc_w-1:0] r12_im;
    } dump_rec_t;

endpackage

`default_nettype wire
